// File: vlog.f
+incdir+design
design/renameTypesPkg.sv
design/robPkg.sv
design/robIf.sv
design/tagAllocator.sv
design/reorderBuffer.sv
design/commitUnit.sv
design/regfile.sv
design/renameCore.sv
bench/renameCore_sva.sv
bench/renameCore_tb.sv

// File: Makefile
# Verilator build and run for the rename core testbench

VERILATOR ?= verilator
TOP       ?= renameCore_tb
FILELIST  ?= vlog.f
BUILD     ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
SIMARGS   ?= +verilator+error+limit+1000

SRCS := $(shell grep -v '^+' $(FILELIST)) $(wildcard design/*.svh)
BIN  := $(BUILD)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD) -o V$(TOP)

run: $(BIN)
	./$(BIN) $(SIMARGS) | tee $(LOG)
	grep -q '\*\* PASS \*\*' $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)

// File: bench/renameCore_tb.sv
`timescale 1ns/100ps

`include "core_params.svh"

module renameCore_tb import renameTypesPkg::*; ();
    localparam int NumInst       = 400;
    localparam int TimeoutCycles = NumInst * 10;  // roughly five times the expected run

    logic     clk;
    logic     rst;
    logic     rdy;
    logic     instValid;
    regName_t instDest;
    regName_t instSrc1;
    regName_t instSrc2;
    logic     resultValid;
    tag_t     resultTag;
    data_t    resultData;
    regName_t readName;
    logic     instReady;
    tag_t     instTag;
    tag_t     src1Tag;
    data_t    src1Data;
    tag_t     src2Tag;
    data_t    src2Data;
    tag_t     readTag;
    data_t    readData;
    logic     commitValid;
    regName_t commitReg;
    data_t    commitData;

    regName_t seqDest [NumInst];  // destination of each instruction in acceptance order
    data_t    seqData [NumInst];
    int       pend [$];           // accepted instructions still waiting for a result
    int       accepted   = 0;
    int       committed  = 0;
    int       cycles     = 0;
    int       readErrors = 0;
    logic     took       = 1'b0;
    regName_t prevDest   = '0;

    renameCore i_renameCore (.*);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles > TimeoutCycles) begin
            $display("timeout, the DUT did not drain within %0d cycles", TimeoutCycles);
            $display("** FAIL **");
            $finish;
        end
    end

    task automatic runCycle();
        int k;
        @(negedge clk);
        if (took)
            instValid = 1'b0;  // the source holds an instruction until it is taken
        took = 1'b0;
        rdy = (accepted < NumInst) ? ($urandom % 8 != 0) : 1'b1;
        if (!instValid && accepted < NumInst && $urandom % 4 != 0) begin
            instValid = 1'b1;
            instDest  = regName_t'($urandom);
        end
        instSrc1 = ($urandom % 4 == 0) ? '0 : regName_t'($urandom);
        instSrc2 = ($urandom % 4 == 0) ? '0 : regName_t'($urandom);
        readName = ($urandom % 2 == 0) ? prevDest : regName_t'($urandom);
        resultValid = 1'b0;
        if (pend.size() > 0 && $urandom % 2 == 0) begin
            k = $urandom % pend.size();
            resultValid = 1'b1;
            resultTag   = tag_t'(pend[k] % `ROB_DEPTH + 1);  // tags are handed out in wrap order
            resultData  = $urandom;
            seqData[pend[k]] = resultData;
            pend.delete(k);
        end
        @(posedge clk);
        if (instValid && instReady) begin
            seqDest[accepted] = instDest;
            pend.push_back(accepted);
            accepted++;
            prevDest = instDest;
            took = 1'b1;
        end
        if (commitValid)
            committed++;
    endtask

    // the youngest writer of each register decides its final value
    task automatic readBack();
        data_t expData [`REG_COUNT];
        for (int r = 0; r < `REG_COUNT; r++)
            expData[r] = '0;
        for (int i = 0; i < NumInst; i++)
            if (seqDest[i] != '0)
                expData[seqDest[i]] = seqData[i];
        for (int r = 0; r < `REG_COUNT; r++) begin
            @(negedge clk);
            instValid   = 1'b0;
            resultValid = 1'b0;
            readName    = regName_t'(r);
            @(posedge clk);
            readCheck: assert (readData == expData[r] && readTag == TAG_FREE) else begin
                readErrors++;
                $display("Fail readback r%0d: expected data %h tag 0, actual data %h tag %0d",
                         r, expData[r], readData, readTag);
            end
        end
    endtask

    task automatic finishRun();
        int assertFails;
        assertFails = i_renameCore.i_sva.failCount;
        $display("readback errors: %0d, assertion failures: %0d", readErrors, assertFails);
        if (readErrors == 0 && assertFails == 0)
            $display("** PASS **");
        else
            $display("** FAIL **");
        $finish;
    endtask

    initial begin
        void'($urandom(32'hb730));
        rst         = 1'b1;
        rdy         = 1'b0;
        instValid   = 1'b0;
        instDest    = '0;
        instSrc1    = '0;
        instSrc2    = '0;
        resultValid = 1'b0;
        resultTag   = '0;
        resultData  = '0;
        readName    = '0;
        repeat (4) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        while (accepted < NumInst || committed < accepted)
            runCycle();
        readBack();
        finishRun();
    end
endmodule

// File: bench/renameCore_sva.sv
`timescale 1ns/100ps

`include "core_params.svh"

module renameCore_sva import renameTypesPkg::*; (
    input logic     clk,
    input logic     rst,
    input logic     rdy,
    input logic     instValid,
    input logic     instReady,
    input tag_t     instTag,
    input regName_t instDest,
    input regName_t instSrc1,
    input regName_t instSrc2,
    input regName_t readName,
    input tag_t     src1Tag,
    input tag_t     src2Tag,
    input tag_t     readTag,
    input data_t    src1Data,
    input data_t    src2Data,
    input data_t    readData,
    input logic     resultValid,
    input tag_t     resultTag,
    input data_t    resultData,
    input logic     commitValid,
    input regName_t commitReg,
    input data_t    commitData,
    input tag_t     headTag
);
    int                         failCount = 0;
    int                         inFlight;
    tag_t                       accTag;  // tag the next acceptance takes
    tag_t                       lastTag;  // tag the latest acceptance took
    tag_t                       expTag;  // tag the next commit must carry
    logic [2**`TAG_WIDTH-1:0]   live;
    regName_t                   destOf   [2**`TAG_WIDTH];
    data_t                      lastData [2**`TAG_WIDTH];
    logic                       accept;

    assign accept = instValid && instReady;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            inFlight <= 0;
            accTag   <= tag_t'(1);
            lastTag  <= '0;
            expTag   <= tag_t'(1);
            live     <= '0;
        end else begin
            inFlight <= inFlight + (accept ? 1 : 0) - (commitValid ? 1 : 0);
            if (accept) begin
                live[accTag] <= 1'b1;
                lastTag      <= accTag;
                accTag <= (accTag == tag_t'(`ROB_DEPTH)) ? tag_t'(1) : accTag + tag_t'(1);
            end
            if (commitValid) begin
                live[expTag] <= 1'b0;
                expTag <= (expTag == tag_t'(`ROB_DEPTH)) ? tag_t'(1) : expTag + tag_t'(1);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept)
            destOf[accTag] <= instDest;
        if (resultValid && live[resultTag])
            lastData[resultTag] <= resultData;  // stale tags are dropped like the buffer does
    end

    zeroReg: assert property (@(posedge clk) disable iff (rst)
        (instSrc1 != '0 || (src1Tag == TAG_FREE && src1Data == '0)) &&
        (instSrc2 != '0 || (src2Tag == TAG_FREE && src2Data == '0)) &&
        (readName != '0 || (readTag == TAG_FREE && readData == '0)))
        else begin
            failCount++;
            $error("Fail zeroReg: expected tag 0 data 0, actual %0d/%h %0d/%h %0d/%h",
                   $sampled(src1Tag), $sampled(src1Data), $sampled(src2Tag),
                   $sampled(src2Data), $sampled(readTag), $sampled(readData));
        end

    tagIssue: assert property (@(posedge clk) disable iff (rst)
        instTag == accTag)
        else begin
            failCount++;
            $error("Fail tagIssue: expected tag %0d, actual %0d",
                   $sampled(accTag), $sampled(instTag));
        end

    fullStall: assert property (@(posedge clk) disable iff (rst)
        instReady == (rdy && inFlight != `ROB_DEPTH))
        else begin
            failCount++;
            $error("Fail fullStall: expected instReady %0b, actual %0b",
                   $sampled(rdy) && $sampled(inFlight) != `ROB_DEPTH, $sampled(instReady));
        end

    commitOrder: assert property (@(posedge clk) disable iff (rst)
        commitValid |-> headTag == expTag)
        else begin
            failCount++;
            $error("Fail commitOrder: expected tag %0d, actual %0d",
                   $sampled(expTag), $sampled(headTag));
        end

    commitPayload: assert property (@(posedge clk) disable iff (rst)
        commitValid |-> commitReg == destOf[expTag] && commitData == lastData[expTag])
        else begin
            failCount++;
            $error("Fail commitPayload: expected r%0d %h, actual r%0d %h",
                   destOf[$sampled(expTag)], lastData[$sampled(expTag)],
                   $sampled(commitReg), $sampled(commitData));
        end

    // a rename shows up on the very next lookup unless the commit bypass frees it
    renameVisible: assert property (@(posedge clk) disable iff (rst)
        accept && instDest != '0 |=>
            readName != $past(instDest) || readTag == lastTag ||
            (readTag == TAG_FREE && readData == commitData))
        else begin
            failCount++;
            $error("Fail renameVisible: expected tag %0d on r%0d, actual %0d",
                   $sampled(lastTag), $sampled(readName), $sampled(readTag));
        end
endmodule

bind renameCore renameCore_sva i_sva (.*);

// File: design/renameCore.sv
`timescale 1ns/100ps

`include "core_params.svh"

module renameCore (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          rdy,
    input  logic                          instValid,
    input  logic [$clog2(`REG_COUNT)-1:0] instDest,
    input  logic [$clog2(`REG_COUNT)-1:0] instSrc1,
    input  logic [$clog2(`REG_COUNT)-1:0] instSrc2,
    input  logic                          resultValid,
    input  logic [`TAG_WIDTH-1:0]         resultTag,
    input  logic [`DATA_WIDTH-1:0]        resultData,
    input  logic [$clog2(`REG_COUNT)-1:0] readName,
    output logic                          instReady,
    output logic [`TAG_WIDTH-1:0]         instTag,
    output logic [`TAG_WIDTH-1:0]         src1Tag,
    output logic [`DATA_WIDTH-1:0]        src1Data,
    output logic [`TAG_WIDTH-1:0]         src2Tag,
    output logic [`DATA_WIDTH-1:0]        src2Data,
    output logic [`TAG_WIDTH-1:0]         readTag,
    output logic [`DATA_WIDTH-1:0]        readData,
    output logic                          commitValid,
    output logic [$clog2(`REG_COUNT)-1:0] commitReg,
    output logic [`DATA_WIDTH-1:0]        commitData
);
    // head entry is destination, data and ready bit
    localparam int EntryBits = $clog2(`REG_COUNT) + `DATA_WIDTH + 1;

    robAllocIf    alloc ();
    commitWriteIf cw ();

    logic                          enRename;
    logic [$clog2(`REG_COUNT)-1:0] renameReg;
    logic [`TAG_WIDTH-1:0]         renameTag;
    logic                          pop;
    logic                          headValid;
    logic [EntryBits-1:0]          headEntry;
    logic [`TAG_WIDTH-1:0]         headTag;

    tagAllocator i_tagAllocator (
        .clk, .rst, .rdy, .instValid, .instDest, .instReady, .instTag,
        .alloc(alloc.producer), .enRename, .renameReg, .renameTag
    );

    reorderBuffer i_reorderBuffer (
        .clk, .rst, .alloc(alloc.buffer), .resultValid, .resultTag, .resultData,
        .pop, .headValid, .headEntry, .headTag
    );

    commitUnit i_commitUnit (
        .rdy, .headValid, .headEntry, .headTag, .pop, .cw(cw.source),
        .commitValid, .commitReg, .commitData
    );

    // third port serves architectural state reads from outside
    regfile i_regfile (
        .clk, .rst, .cw(cw.sink), .enRename, .renameReg, .renameTag,
        .name1(instSrc1), .name2(instSrc2), .name3(readName),
        .tag1(src1Tag), .tag2(src2Tag), .tag3(readTag),
        .data1(src1Data), .data2(src2Data), .data3(readData)
    );
endmodule

// File: design/regfile.sv
`timescale 1ns/100ps

`include "core_params.svh"

module regfile import renameTypesPkg::*; (
    input  logic     clk,
    input  logic     rst,
    commitWriteIf.sink cw,
    input  logic     enRename,
    input  regName_t renameReg,
    input  tag_t     renameTag,
    input  regName_t name1,
    input  regName_t name2,
    input  regName_t name3,
    output tag_t     tag1,
    output tag_t     tag2,
    output tag_t     tag3,
    output data_t    data1,
    output data_t    data2,
    output data_t    data3
);
    data_t    dataArr [`REG_COUNT];
    tag_t     tagArr  [`REG_COUNT];
    regName_t names   [3];
    tag_t     tags    [3];
    data_t    datas   [3];
    logic     freeTag;

    // a younger rename carrying the same tag keeps the register pending
    assign freeTag = tagArr[cw.name] == cw.tag &&
                     !(enRename && renameReg == cw.name && renameTag == cw.tag);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int r = 0; r < `REG_COUNT; r++) begin
                dataArr[r] <= '0;
                tagArr[r]  <= TAG_FREE;
            end
        end else begin
            if (cw.en && cw.name != '0) begin
                dataArr[cw.name] <= cw.data;
                if (freeTag)
                    tagArr[cw.name] <= TAG_FREE;
            end
            // placed after the commit so a rename of the same register wins
            if (enRename && renameReg != '0)
                tagArr[renameReg] <= renameTag;
        end
    end

    assign names[0] = name1;
    assign names[1] = name2;
    assign names[2] = name3;

    // the value being committed this cycle is forwarded when it still owns the register
    for (genvar p = 0; p < 3; p++) begin : g_read
        logic hit;

        assign hit = cw.en && cw.name == names[p] && names[p] != '0 &&
                     cw.tag == tagArr[names[p]];

        assign tags[p]  = hit ? TAG_FREE : tagArr[names[p]];
        assign datas[p] = hit ? cw.data : dataArr[names[p]];
    end

    assign tag1  = tags[0];
    assign tag2  = tags[1];
    assign tag3  = tags[2];
    assign data1 = datas[0];
    assign data2 = datas[1];
    assign data3 = datas[2];
endmodule

// File: design/commitUnit.sv
`timescale 1ns/100ps

module commitUnit import renameTypesPkg::*; import robPkg::*; (
    input  logic      rdy,
    input  logic      headValid,
    input  robEntry_t headEntry,
    input  tag_t      headTag,
    output logic      pop,
    commitWriteIf.source cw,
    output logic      commitValid,
    output regName_t  commitReg,
    output data_t     commitData
);
    logic fire;

    // retire only the oldest entry and only once its result is in
    assign fire = rdy && headValid && headEntry.ready;

    assign pop = fire;

    assign cw.en   = fire;
    assign cw.name = headEntry.dest;
    assign cw.data = headEntry.data;
    assign cw.tag  = headTag;  // lets the register file tell if a younger rename owns it

    assign commitValid = fire;
    assign commitReg   = headEntry.dest;
    assign commitData  = headEntry.data;
endmodule

// File: design/reorderBuffer.sv
`timescale 1ns/100ps

`include "core_params.svh"

module reorderBuffer import renameTypesPkg::*; import robPkg::*; (
    input  logic      clk,
    input  logic      rst,
    robAllocIf.buffer alloc,
    input  logic      resultValid,
    input  tag_t      resultTag,
    input  data_t     resultData,
    input  logic      pop,
    output logic      headValid,
    output robEntry_t headEntry,
    output tag_t      headTag
);
    robEntry_t                   entries [`ROB_DEPTH];
    logic [`ROB_DEPTH-1:0]       busy;  // slot holds an outstanding instruction
    robSlot_t                    head;
    logic [$clog2(`ROB_DEPTH):0] count;
    robSlot_t                    pushSlot;
    robSlot_t                    resultSlot;
    logic                        resultHit;

    assign pushSlot   = robSlot_t'(alloc.tag - tag_t'(1));
    assign resultSlot = robSlot_t'(resultTag - tag_t'(1));

    // stray or stale tags must not touch a slot
    assign resultHit = resultValid && resultTag != TAG_FREE &&
                       resultTag <= tag_t'(`ROB_DEPTH) && busy[resultSlot];

    assign alloc.full = count == `ROB_DEPTH;

    assign headValid = busy[head];
    assign headEntry = entries[head];
    assign headTag   = tag_t'(head) + tag_t'(1);

    always_ff @(posedge clk) begin
        if (alloc.push)
            entries[pushSlot] <= '{dest: alloc.destReg, data: '0, ready: 1'b0};
        if (resultHit) begin
            entries[resultSlot].data  <= resultData;
            entries[resultSlot].ready <= 1'b1;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            busy  <= '0;
            head  <= '0;
            count <= '0;
        end else begin
            if (alloc.push)
                busy[pushSlot] <= 1'b1;
            if (pop) begin
                busy[head] <= 1'b0;
                head       <= head + 1'b1;  // depth is a power of two so this wraps
            end
            case ({alloc.push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end
endmodule

// File: design/tagAllocator.sv
`timescale 1ns/100ps

`include "core_params.svh"

module tagAllocator import renameTypesPkg::*; (
    input  logic     clk,
    input  logic     rst,
    input  logic     rdy,
    input  logic     instValid,
    input  regName_t instDest,
    output logic     instReady,
    output tag_t     instTag,
    robAllocIf.producer alloc,
    output logic     enRename,
    output regName_t renameReg,
    output tag_t     renameTag
);
    tag_t nextTag;
    logic accept;

    assign instReady = rdy && !alloc.full;
    assign accept    = instValid && instReady;
    assign instTag   = nextTag;  // the tag this cycle's acceptance would take

    assign alloc.push    = accept;
    assign alloc.destReg = instDest;
    assign alloc.tag     = nextTag;

    // register 0 is filtered out in the register file, the slot is still taken
    assign enRename  = accept;
    assign renameReg = instDest;
    assign renameTag = nextTag;

    // tags run 1..ROB_DEPTH in order, 0 stays reserved
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            nextTag <= tag_t'(1);
        end else if (accept) begin
            if (nextTag == tag_t'(`ROB_DEPTH))
                nextTag <= tag_t'(1);
            else
                nextTag <= nextTag + tag_t'(1);
        end
    end
endmodule

// File: design/robIf.sv
`timescale 1ns/100ps

// allocation of a reorder slot at rename time
interface robAllocIf import renameTypesPkg::*; ();
    logic     push;     // one-cycle strobe, never while full
    regName_t destReg;
    tag_t     tag;
    logic     full;

    modport producer (
        output push, destReg, tag,
        input  full
    );

    modport buffer (
        input  push, destReg, tag,
        output full
    );
endinterface

// retire write into the architectural register file
interface commitWriteIf import renameTypesPkg::*; ();
    logic     en;
    regName_t name;
    data_t    data;
    tag_t     tag;

    modport source (output en, name, data, tag);

    modport sink (input en, name, data, tag);
endinterface

// File: design/robPkg.sv
`include "core_params.svh"

package robPkg;
    import renameTypesPkg::*;

    typedef logic [$clog2(`ROB_DEPTH)-1:0] robSlot_t;

    typedef struct packed {
        regName_t dest;
        data_t    data;
        logic     ready;  // result has arrived
    } robEntry_t;

endpackage

// File: design/renameTypesPkg.sv
`include "core_params.svh"

package renameTypesPkg;

    // architectural register name
    typedef logic [$clog2(`REG_COUNT)-1:0] regName_t;

    typedef logic [`DATA_WIDTH-1:0] data_t;

    // rename tag handed out by the allocator
    typedef logic [`TAG_WIDTH-1:0] tag_t;

    localparam tag_t TAG_FREE = '0;  // no pending writer

endpackage

// File: design/core_params.svh
`ifndef CORE_PARAMS_SVH
`define CORE_PARAMS_SVH

// architectural register count, register 0 is hardwired to zero
`define REG_COUNT 32

`define DATA_WIDTH 32

// tag 0 is reserved to mean the register holds committed data
`define TAG_WIDTH 4

`define ROB_DEPTH 8  // tag t lives in slot t-1

`endif
